// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_wts_sound_core
FILELIST   := list.f
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing -Wno-fatal
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := SIMULATION PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== design/wts_bus_pkg.sv ====
// CPU-side types for the sound core: Wishbone request and response and the wave RAM port
`default_nettype none

`include "wts_defs.svh"

package wts_bus_pkg;

	// Master to slave, held by the master until ack
	typedef struct packed {
		logic                          cyc;
		logic                          stb;
		logic                          we;
		logic [`WTS_RAM_ABITS-1:0]     adr;
		logic [`WTS_SAMPLE_BITS-1:0]   dat;
	} wb_req_t;

	// Slave to master, dat is only meaningful while ack is high
	typedef struct packed {
		logic                          ack;
		logic [`WTS_SAMPLE_BITS-1:0]   dat;
	} wb_rsp_t;

	// One RAM access per cycle, chosen by the arbiter
	typedef struct packed {
		logic                          we;
		logic [`WTS_RAM_ABITS-1:0]     addr;
		logic [`WTS_SAMPLE_BITS-1:0]   wdata;
	} ram_port_t;

endpackage

`default_nettype wire

// ==== design/wts_channel_volume.sv ====
// Volume and panning stage; scales the sample read for the previous slot and routes it per side
`default_nettype none

`include "wts_defs.svh"

module wts_channel_volume (
	input  logic                         clk,
	input  logic                         nreset,
	input  logic [2:0]                   slot,
	input  wts_voice_pkg::voice_regs_t   voice_regs,
	input  wts_voice_pkg::sample_t       ram_q,
	output wts_voice_pkg::mix_t          mix
);

	import wts_voice_pkg::*;

	localparam logic [`WTS_SLOT_BITS-1:0] CPU_SLOT = `WTS_CPU_SLOT;

	logic [`WTS_SLOT_BITS-1:0]                      ff_slot_d;
	logic                                           w_active;
	voice_reg_t                                     w_voice;
	logic signed [`WTS_SAMPLE_BITS+`WTS_VOL_BITS:0] w_product;
	sample_t                                        w_contrib;

	// RAM data lags its address by one cycle
	always_ff @(posedge clk) begin
		if (!nreset) begin
			ff_slot_d <= CPU_SLOT;
		end else begin
			ff_slot_d <= slot;
		end
	end

	assign w_active = (int'(ff_slot_d) < `WTS_VOICES);

	always_comb begin
		w_voice = '0;
		if (w_active) begin
			w_voice = voice_regs[ff_slot_d];
		end
	end

	// Volume is unsigned, so it gets a zero sign bit before the signed multiply
	assign w_product = ram_q * $signed({1'b0, w_voice.volume});

	// Dropping the low four bits is a floor divide by 16
	assign w_contrib = w_product[`WTS_VOL_BITS +: `WTS_SAMPLE_BITS];

	always_comb begin
		mix.valid     = w_active;
		mix.frame_end = (ff_slot_d == CPU_SLOT);
		mix.left      = w_voice.enable[1] ? w_contrib : '0;
		mix.right     = w_voice.enable[0] ? w_contrib : '0;
	end

endmodule

`default_nettype wire

// ==== design/wts_defs.svh ====
// Shared size constants for the wave-table sound core, included by the packages and sized RTL
`ifndef WTS_DEFS_SVH
`define WTS_DEFS_SVH

// Voices and the slot frame
`define WTS_VOICES      5
`define WTS_CPU_SLOT    5
`define WTS_SLOT_BITS   3

// Wave RAM geometry, voice number above a 32-sample index
`define WTS_WAVE_BITS   5
`define WTS_RAM_ABITS   8
`define WTS_SAMPLE_BITS 8

// Voice register and output widths
`define WTS_FREQ_BITS   12
`define WTS_VOL_BITS    4
`define WTS_OUT_BITS    12

`endif

// ==== design/wts_sound_core.sv ====
// Top of the five-voice wave-table sound core; connect a Wishbone master and the voice registers
`default_nettype none

module wts_sound_core (
	input  logic                         clk,
	input  logic                         nreset,
	input  wts_bus_pkg::wb_req_t         wb_req,
	output wts_bus_pkg::wb_rsp_t         wb_rsp,
	input  wts_voice_pkg::voice_regs_t   voice_regs,
	input  logic [4:0]                   key_on,
	output logic [11:0]                  left_out,
	output logic [11:0]                  right_out
);

	import wts_bus_pkg::*;
	import wts_voice_pkg::*;

	logic [2:0]  w_slot;
	logic [4:0]  w_wave_address;
	ram_port_t   w_ram_port;
	sample_t     w_ram_q;
	mix_t        w_mix;

	wts_wave_ram_arbiter u_wave_ram_arbiter (
		.clk            ( clk             ),
		.nreset         ( nreset          ),
		.wb_req         ( wb_req          ),
		.wb_rsp         ( wb_rsp          ),
		.wave_address   ( w_wave_address  ),
		.ram_q          ( w_ram_q         ),
		.slot           ( w_slot          ),
		.ram_port       ( w_ram_port      )
	);

	wts_wave_ram u_wave_ram (
		.clk            ( clk             ),
		.ram_port       ( w_ram_port      ),
		.ram_q          ( w_ram_q         )
	);

	wts_tone_generator u_tone_generator (
		.clk            ( clk             ),
		.nreset         ( nreset          ),
		.slot           ( w_slot          ),
		.key_on         ( key_on          ),
		.voice_regs     ( voice_regs      ),
		.wave_address   ( w_wave_address  )
	);

	wts_channel_volume u_channel_volume (
		.clk            ( clk             ),
		.nreset         ( nreset          ),
		.slot           ( w_slot          ),
		.voice_regs     ( voice_regs      ),
		.ram_q          ( w_ram_q         ),
		.mix            ( w_mix           )
	);

	wts_stereo_mixer u_stereo_mixer (
		.clk            ( clk             ),
		.nreset         ( nreset          ),
		.mix            ( w_mix           ),
		.left_out       ( left_out        ),
		.right_out      ( right_out       )
	);

endmodule

`default_nettype wire

// ==== design/wts_stereo_mixer.sv ====
// Frame mixer; sums the voice contributions per side and outputs offset-binary words per frame
`default_nettype none

`include "wts_defs.svh"

module wts_stereo_mixer (
	input  logic                         clk,
	input  logic                         nreset,
	input  wts_voice_pkg::mix_t          mix,
	output logic [11:0]                  left_out,
	output logic [11:0]                  right_out
);

	localparam int                      EXT_BITS = `WTS_OUT_BITS - `WTS_SAMPLE_BITS;
	localparam logic [`WTS_OUT_BITS-1:0] MIDSCALE = 1 << (`WTS_OUT_BITS - 1);

	logic [`WTS_OUT_BITS-1:0]  w_left_ext;
	logic [`WTS_OUT_BITS-1:0]  w_right_ext;
	logic [`WTS_OUT_BITS-1:0]  ff_left_acc;
	logic [`WTS_OUT_BITS-1:0]  ff_right_acc;
	logic [`WTS_OUT_BITS-1:0]  ff_left_out;
	logic [`WTS_OUT_BITS-1:0]  ff_right_out;

	assign w_left_ext  = {{EXT_BITS{mix.left[`WTS_SAMPLE_BITS-1]}}, mix.left};
	assign w_right_ext = {{EXT_BITS{mix.right[`WTS_SAMPLE_BITS-1]}}, mix.right};

	// Two's complement sums; flipping the top bit turns them into offset binary
	always_ff @(posedge clk) begin
		if (!nreset) begin
			ff_left_acc  <= '0;
			ff_right_acc <= '0;
			ff_left_out  <= MIDSCALE;
			ff_right_out <= MIDSCALE;
		end else if (mix.frame_end) begin
			ff_left_acc  <= '0;
			ff_right_acc <= '0;
			ff_left_out  <= ff_left_acc ^ MIDSCALE;
			ff_right_out <= ff_right_acc ^ MIDSCALE;
		end else if (mix.valid) begin
			ff_left_acc  <= ff_left_acc + w_left_ext;
			ff_right_acc <= ff_right_acc + w_right_ext;
		end
	end

	assign left_out  = ff_left_out;
	assign right_out = ff_right_out;

endmodule

`default_nettype wire

// ==== design/wts_tone_generator.sv ====
// Per-voice pitch counters that step each voice through its 32-sample wave; key-on restarts it
`default_nettype none

`include "wts_defs.svh"

module wts_tone_generator (
	input  logic                         clk,
	input  logic                         nreset,
	input  logic [2:0]                   slot,
	input  logic [4:0]                   key_on,
	input  wts_voice_pkg::voice_regs_t   voice_regs,
	output logic [4:0]                   wave_address
);

	logic [`WTS_FREQ_BITS-1:0]  ff_count    [`WTS_VOICES];
	logic [`WTS_WAVE_BITS-1:0]  ff_address  [`WTS_VOICES];
	logic                       ff_key_pend [`WTS_VOICES];

	// Address of the voice that owns the current slot
	always_comb begin
		wave_address = '0;
		if (int'(slot) < `WTS_VOICES) begin
			wave_address = ff_address[slot];
		end
	end

	// Each voice only moves in its own slot, so one step per frame
	always_ff @(posedge clk) begin
		if (!nreset) begin
			for (int v = 0; v < `WTS_VOICES; v++) begin
				ff_count[v]    <= '0;
				ff_address[v]  <= '0;
				ff_key_pend[v] <= 1'b0;
			end
		end else begin
			for (int v = 0; v < `WTS_VOICES; v++) begin
				if (int'(slot) == v) begin
					ff_key_pend[v] <= 1'b0;
					if (key_on[v] || ff_key_pend[v]) begin
						ff_count[v]   <= '0;
						ff_address[v] <= '0;
					end else if (ff_count[v] == '0) begin
						ff_count[v]   <= voice_regs[v].frequency_count;
						ff_address[v] <= ff_address[v] + 1'b1;
					end else begin
						ff_count[v]   <= ff_count[v] - 1'b1;
					end
				end else if (key_on[v]) begin
					// Hold a short pulse until the voice's slot comes round
					ff_key_pend[v] <= 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/wts_voice_pkg.sv ====
// Audio-side types for the sound core: samples, voice registers and the mixer feed
`default_nettype none

`include "wts_defs.svh"

package wts_voice_pkg;

	typedef logic signed [`WTS_SAMPLE_BITS-1:0] sample_t;

	// Enable bit 1 routes to left and bit 0 routes to right
	typedef struct packed {
		logic [`WTS_VOL_BITS-1:0]      volume;
		logic [1:0]                    enable;
		logic [`WTS_FREQ_BITS-1:0]     frequency_count;
	} voice_reg_t;

	typedef voice_reg_t [`WTS_VOICES-1:0] voice_regs_t;

	// Scaled contributions of one slot, plus the frame marker
	typedef struct packed {
		logic                          valid;
		logic                          frame_end;
		sample_t                       left;
		sample_t                       right;
	} mix_t;

endpackage

`default_nettype wire

// ==== design/wts_wave_ram.sv ====
// Wave sample storage, 256 bytes, one synchronous access per cycle with registered read data
`default_nettype none

`include "wts_defs.svh"

module wts_wave_ram (
	input  logic                         clk,
	input  wts_bus_pkg::ram_port_t       ram_port,
	output wts_voice_pkg::sample_t       ram_q
);

	import wts_voice_pkg::*;

	logic [`WTS_SAMPLE_BITS-1:0]  mem [2**`WTS_RAM_ABITS];
	sample_t                      ff_q;

	// A write returns the old byte on the read side
	always_ff @(posedge clk) begin
		if (ram_port.we) begin
			mem[ram_port.addr] <= ram_port.wdata;
		end
		ff_q <= mem[ram_port.addr];
	end

	assign ram_q = ff_q;

endmodule

`default_nettype wire

// ==== design/wts_wave_ram_arbiter.sv ====
// Slot counter and wave RAM arbiter; slots 0 to 4 play voices, slot 5 serves the Wishbone slave
`default_nettype none

`include "wts_defs.svh"

module wts_wave_ram_arbiter (
	input  logic                         clk,
	input  logic                         nreset,
	input  wts_bus_pkg::wb_req_t         wb_req,
	output wts_bus_pkg::wb_rsp_t         wb_rsp,
	input  logic [4:0]                   wave_address,
	input  wts_voice_pkg::sample_t       ram_q,
	output logic [2:0]                   slot,
	output wts_bus_pkg::ram_port_t       ram_port
);

	localparam logic [`WTS_SLOT_BITS-1:0] CPU_SLOT = `WTS_CPU_SLOT;

	logic [`WTS_SLOT_BITS-1:0]  ff_slot;
	logic                       ff_ack;
	logic                       w_cpu_slot;
	logic                       w_pending;
	logic                       w_grant;

	// ----------------------------------------
	// Slot frame
	// ----------------------------------------
	assign w_cpu_slot = (ff_slot == CPU_SLOT);

	always_ff @(posedge clk) begin
		if (!nreset) begin
			ff_slot <= '0;
		end else if (w_cpu_slot) begin
			ff_slot <= '0;
		end else begin
			ff_slot <= ff_slot + 1'b1;
		end
	end

	assign slot = ff_slot;

	// ----------------------------------------
	// Wishbone slave
	// ----------------------------------------
	// A request still waiting for its ack is served in the next CPU slot
	assign w_pending = wb_req.cyc & wb_req.stb & ~ff_ack;
	assign w_grant   = w_cpu_slot & w_pending;

	// Ack lines up with the RAM output of the granted access
	always_ff @(posedge clk) begin
		if (!nreset) begin
			ff_ack <= 1'b0;
		end else begin
			ff_ack <= w_grant;
		end
	end

	assign wb_rsp.ack = ff_ack;
	assign wb_rsp.dat = ram_q;

	// ----------------------------------------
	// RAM port multiplexer
	// ----------------------------------------
	always_comb begin
		ram_port.wdata = wb_req.dat;
		if (w_cpu_slot) begin
			ram_port.we   = w_grant & wb_req.we;
			ram_port.addr = wb_req.adr;
		end else begin
			// Playback reads the voice's own 32-byte region
			ram_port.we   = 1'b0;
			ram_port.addr = {ff_slot, wave_address};
		end
	end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+design
design/wts_bus_pkg.sv
design/wts_voice_pkg.sv
design/wts_wave_ram_arbiter.sv
design/wts_wave_ram.sv
design/wts_tone_generator.sv
design/wts_channel_volume.sv
design/wts_stereo_mixer.sv
design/wts_sound_core.sv
verif/tb_wts_sound_core.sv

// ==== verif/tb_wts_sound_core.sv ====
// Random self-checking testbench for the sound core; compile with list.f, top tb_wts_sound_core
`default_nettype none

`include "wts_defs.svh"

module tb_wts_sound_core;

	import wts_bus_pkg::*;
	import wts_voice_pkg::*;

	localparam int FRAME         = `WTS_CPU_SLOT + 1;
	localparam int WB_TIMEOUT    = 20;
	localparam int WB_MAX_WAIT   = 7;
	localparam int SETTLE_MISSES = 3 * FRAME;
	localparam int STABLE_CYCLES = 2 * FRAME + 2;
	localparam int KEY_TIMEOUT   = 200;

	logic                      clk;
	logic                      nreset;
	wb_req_t                   wb_req;
	wb_rsp_t                   wb_rsp;
	voice_regs_t               voice_regs;
	logic [`WTS_VOICES-1:0]    key_on;
	logic [`WTS_OUT_BITS-1:0]  left_out;
	logic [`WTS_OUT_BITS-1:0]  right_out;

	integer       seed;
	int           value_errors;
	int           protocol_errors;
	sample_t      ram_model [2**`WTS_RAM_ABITS];
	sample_t      wave_value [`WTS_VOICES];
	voice_regs_t  regs;

	wts_sound_core i_wts_sound_core (
		.clk        ( clk        ),
		.nreset     ( nreset     ),
		.wb_req     ( wb_req     ),
		.wb_rsp     ( wb_rsp     ),
		.voice_regs ( voice_regs ),
		.key_on     ( key_on     ),
		.left_out   ( left_out   ),
		.right_out  ( right_out  )
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ----------------------------------------
	// Checks and reference model
	// ----------------------------------------
	task automatic compare_sample(input string name, input sample_t expected, input sample_t actual);
		if (actual !== expected) begin
			value_errors++;
			$display("FAIL %0t %s expected %h got %h", $time, name, expected, actual);
		end
	endtask

	task automatic compare_word(input string name, input logic [`WTS_OUT_BITS-1:0] expected,
			input logic [`WTS_OUT_BITS-1:0] actual);
		if (actual !== expected) begin
			value_errors++;
			$display("FAIL %0t %s expected %h got %h", $time, name, expected, actual);
		end
	endtask

	function automatic logic [31:0] next_random();
		return $random(seed);
	endfunction

	// Floor of v*n/16, since an arithmetic right shift of a signed int rounds down
	function automatic int scaled(input sample_t v, input logic [`WTS_VOL_BITS-1:0] n);
		int product;
		product = int'(v) * int'(n);
		return product >>> 4;
	endfunction

	// Side 1 is left and side 0 is right; the sum wraps at 12 bits around midscale
	function automatic logic [`WTS_OUT_BITS-1:0] expected_side(input logic side);
		int sum;
		sum = 2048;
		for (int v = 0; v < `WTS_VOICES; v++) begin
			if (regs[v].enable[side]) begin
				sum += scaled(wave_value[v], regs[v].volume);
			end
		end
		return 12'(sum);
	endfunction

	// ----------------------------------------
	// Wishbone master
	// ----------------------------------------
	task automatic wb_access(input logic we, input logic [7:0] adr, input sample_t dat,
			output sample_t rdata);
		wb_req_t req;
		int      cycles;
		logic    got;
		req.cyc = 1'b1;
		req.stb = 1'b1;
		req.we  = we;
		req.adr = adr;
		req.dat = dat;
		cycles  = 0;
		got     = 1'b0;
		rdata   = '0;
		@(posedge clk);
		wb_req <= req;
		while (!got && cycles < WB_TIMEOUT) begin
			@(posedge clk);
			cycles++;
			if (wb_rsp.ack) begin
				got   = 1'b1;
				rdata = wb_rsp.dat;
			end
		end
		wb_req <= '0;
		if (!got) begin
			protocol_errors++;
			$display("ERROR %0t no Wishbone ack within %0d cycles at address %h", $time, WB_TIMEOUT, adr);
		end else if (cycles > WB_MAX_WAIT) begin
			protocol_errors++;
			$display("ERROR %0t Wishbone ack took %0d cycles at address %h", $time, cycles, adr);
		end
	endtask

	task automatic write_byte(input logic [7:0] adr, input sample_t dat);
		sample_t ignored;
		wb_access(1'b1, adr, dat, ignored);
		ram_model[adr] = dat;
	endtask

	task automatic read_check(input logic [7:0] adr);
		sample_t q;
		wb_access(1'b0, adr, '0, q);
		compare_sample("wb_rsp.dat", ram_model[adr], q);
	endtask

	task automatic apply_regs();
		@(posedge clk);
		voice_regs <= regs;
	endtask

	// A match has to hold across two whole frames, so a frame mixed from old and new
	// registers cannot pass for the settled value
	task automatic wait_outputs(input logic [`WTS_OUT_BITS-1:0] exp_left,
			input logic [`WTS_OUT_BITS-1:0] exp_right);
		int stable;
		int misses;
		stable = 0;
		misses = 0;
		while (stable < STABLE_CYCLES && misses < SETTLE_MISSES) begin
			@(posedge clk);
			if (left_out === exp_left && right_out === exp_right) begin
				stable++;
			end else begin
				stable = 0;
				misses++;
			end
		end
		if (stable < STABLE_CYCLES) begin
			protocol_errors++;
			$display("ERROR %0t outputs did not settle within %0d frames", $time, SETTLE_MISSES / FRAME);
		end
		repeat (FRAME) @(posedge clk);
		compare_word("left_out", exp_left, left_out);
		compare_word("right_out", exp_right, right_out);
	endtask

	// ----------------------------------------
	// Test sequence
	// ----------------------------------------
	initial begin
		logic [31:0]               r;
		int                        k;
		int                        step;
		int                        cycles;
		logic                      seen;
		sample_t                   base;
		logic [`WTS_OUT_BITS-1:0]  expect_word;
		seed            = 32'h8069_f562;
		value_errors    = 0;
		protocol_errors = 0;
		nreset          = 1'b0;
		wb_req          = '0;
		voice_regs      = '0;
		key_on          = '0;
		regs            = '0;
		for (int v = 0; v < `WTS_VOICES; v++) begin
			wave_value[v] = '0;
		end
		repeat (4) @(posedge clk);
		nreset <= 1'b1;

		@(posedge clk);
		compare_word("left_out", 12'h800, left_out);
		compare_word("right_out", 12'h800, right_out);
		if (wb_rsp.ack !== 1'b0) begin
			value_errors++;
			$display("FAIL %0t wb_rsp.ack expected 0 got %b", $time, wb_rsp.ack);
		end

		// Known contents everywhere first, then random traffic
		for (int a = 0; a < 2**`WTS_RAM_ABITS; a++) begin
			write_byte(8'(a), sample_t'(8'(a * 37 + 11)));
		end
		for (int i = 0; i < 64; i++) begin
			r = next_random();
			write_byte(r[7:0], r[15:8]);
		end
		for (int i = 0; i < 64; i++) begin
			r = next_random();
			read_check(r[7:0]);
		end

		// Constant waves on a random subset of voices
		for (int round = 0; round < 6; round++) begin
			regs = '0;
			for (int v = 0; v < `WTS_VOICES; v++) begin
				r = next_random();
				if (r[14]) begin
					wave_value[v] = r[7:0];
					for (int i = 0; i < 32; i++) begin
						write_byte(8'(v * 32 + i), wave_value[v]);
					end
					regs[v].volume          = r[11:8];
					regs[v].enable          = r[13:12];
					regs[v].frequency_count = r[31:20];
				end
			end
			apply_regs();
			wait_outputs(expected_side(1'b1), expected_side(1'b0));
		end

		// Silence whatever the RAM holds
		regs = '0;
		for (int v = 0; v < `WTS_VOICES; v++) begin
			r = next_random();
			regs[v].enable          = r[13:12];
			regs[v].frequency_count = r[31:20];
		end
		for (int i = 0; i < 16; i++) begin
			r = next_random();
			write_byte(r[7:0], r[15:8]);
		end
		apply_regs();
		wait_outputs(12'h800, 12'h800);

		// Samples spaced by 8 and never 0 or 1 mod 8 give distinct nonzero contributions at
		// full volume, so only sample 0 can produce the expected word
		r    = next_random();
		k    = int'(r[15:0] % 16'd5);
		step = 2 * int'(r[20:16]) + 1;
		base = {r[31:27], 3'd2 + 3'(r[26:24] % 3'd6)};
		for (int i = 0; i < 32; i++) begin
			write_byte(8'(k * 32 + i), sample_t'(8'(int'(base) + 8 * ((i * step) % 32))));
		end
		regs[k].volume          = 4'hf;
		regs[k].enable          = 2'b11;
		regs[k].frequency_count = 12'hfff;
		expect_word = 12'(2048 + scaled(base, 4'hf));
		@(posedge clk);
		voice_regs <= regs;
		key_on     <= 5'(1 << k);
		@(posedge clk);
		key_on <= '0;
		cycles = 1;
		seen   = 1'b0;
		while (!seen && cycles < KEY_TIMEOUT) begin
			@(posedge clk);
			cycles++;
			seen = (left_out === expect_word && right_out === expect_word);
		end
		if (!seen) begin
			protocol_errors++;
			$display("ERROR %0t voice %0d never played sample 0 after key-on", $time, k);
		end
		compare_word("left_out", expect_word, left_out);
		compare_word("right_out", expect_word, right_out);

		$display("Errors: %0d value, %0d protocol", value_errors, protocol_errors);
		if (value_errors + protocol_errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
